// File: id_pkg.sv
// Shared types and constants for the RV32I decode stage, referenced as id_pkg::name
`default_nettype none

package id_pkg;

  ////////////////////
  // Basic widths
  ////////////////////

  typedef logic [31:0] word_t;
  typedef logic [4:0]  rf_addr_t;

  // Link offset for JAL/JALR, no compressed support
  localparam word_t PC_INCR = 32'd4;

  // Major opcodes of the supported base integer classes
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'h03,
    OPC_OP_IMM = 7'h13,
    OPC_AUIPC  = 7'h17,
    OPC_STORE  = 7'h23,
    OPC_OP     = 7'h33,
    OPC_LUI    = 7'h37,
    OPC_BRANCH = 7'h63,
    OPC_JALR   = 7'h67,
    OPC_JAL    = 7'h6f
  } opcode_e;

  ////////////////////
  // Instruction views
  ////////////////////

  // All views are 32 bits, opcode always in [6:0]
  typedef struct packed {
    logic [6:0] funct7;
    rf_addr_t   rs2;
    rf_addr_t   rs1;
    logic [2:0] funct3;
    rf_addr_t   rd;
    logic [6:0] opcode;
  } instr_r_t;

  typedef struct packed {
    logic [11:0] imm;
    rf_addr_t    rs1;
    logic [2:0]  funct3;
    rf_addr_t    rd;
    logic [6:0]  opcode;
  } instr_i_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    rf_addr_t   rs2;
    rf_addr_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } instr_s_t;

  // B format scrambles the offset bits across the word
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    rf_addr_t   rs2;
    rf_addr_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } instr_b_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    rf_addr_t    rd;
    logic [6:0]  opcode;
  } instr_u_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    rf_addr_t   rd;
    logic [6:0] opcode;
  } instr_j_t;

  // One fetched word, read through whichever format applies
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
    instr_s_t s;
    instr_b_t b;
    instr_u_t u;
    instr_j_t j;
  } instr_u;

  ////////////////////
  // Control encodings
  ////////////////////

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG, OP_A_PC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic       {OP_B_REG, OP_B_IMM} op_b_sel_e;
  typedef enum logic       {OP_C_REG, OP_C_BCH} op_c_sel_e;
  typedef enum logic [1:0] {IMM_I, IMM_S, IMM_U, IMM_PCINCR} imm_sel_e;
  typedef enum logic [1:0] {FW_RF, FW_EX, FW_WB} fw_sel_e;
  typedef enum logic [1:0] {XFER_NONE, XFER_JAL, XFER_JALR, XFER_BRANCH} xfer_e;

  ////////////////////
  // Pipeline structs
  ////////////////////

  // Decoder output
  typedef struct packed {
    logic      alu_en;
    alu_op_e   alu_op;
    op_a_sel_e op_a_sel;
    op_b_sel_e op_b_sel;
    op_c_sel_e op_c_sel;
    imm_sel_e  imm_sel;
    logic      lsu_en;
    logic      lsu_we;
    logic [1:0] lsu_size;
    logic      lsu_unsigned;
    logic      rf_we;
    logic [1:0] rf_re;
    xfer_e     xfer;
    logic      illegal;
  } decode_t;

  typedef struct packed {
    logic   valid;
    word_t  pc;
    instr_u instr;
  } if_id_t;

  // Controller bypass and stall controls
  typedef struct packed {
    logic    kill_id;
    logic    halt_id;
    logic    deassert_we;
    fw_sel_e fw_a;
    fw_sel_e fw_b;
  } byp_ctrl_t;

  typedef struct packed {
    logic       valid;
    word_t      pc;
    logic       alu_en;
    alu_op_e    alu_op;
    word_t      operand_a;
    word_t      operand_b;
    word_t      operand_c;
    logic       lsu_en;
    logic       lsu_we;
    logic [1:0] lsu_size;
    logic       lsu_unsigned;
    logic       rf_we;
    rf_addr_t   rf_waddr;
    logic       branch;
    logic       illegal;
  } id_ex_t;

endpackage

`default_nettype wire

// File: id_decoder.sv
// RV32I instruction decoder, maps opcode and funct fields to the ID control struct
`default_nettype none

module id_decoder (
  input  id_pkg::instr_u  instr_i,
  input  logic            deassert_we_i,
  output id_pkg::decode_t dec_o
);

  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic            sub_sel;
  logic            illegal;
  id_pkg::alu_op_e arith_op;
  id_pkg::decode_t dec;

  // Function fields are read through the R view for every format
  assign funct3  = instr_i.r.funct3;
  assign funct7  = instr_i.r.funct7;
  // funct7[5] is an immediate bit for ADDI, so SUB only exists for OP
  assign sub_sel = (instr_i.r.opcode == id_pkg::OPC_OP) && funct7[5];

  // Shared funct3 map for OP and OP-IMM
  always_comb begin
    case (funct3)
      3'b000:  arith_op = sub_sel ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
      3'b001:  arith_op = id_pkg::ALU_SLL;
      3'b010:  arith_op = id_pkg::ALU_SLT;
      3'b011:  arith_op = id_pkg::ALU_SLTU;
      3'b100:  arith_op = id_pkg::ALU_XOR;
      3'b101:  arith_op = funct7[5] ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
      3'b110:  arith_op = id_pkg::ALU_OR;
      default: arith_op = id_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    // Defaults describe a register-register ALU op with nothing enabled
    dec          = '0;
    dec.alu_op   = id_pkg::ALU_ADD;
    dec.op_a_sel = id_pkg::OP_A_REG;
    dec.op_b_sel = id_pkg::OP_B_REG;
    dec.op_c_sel = id_pkg::OP_C_REG;
    dec.imm_sel  = id_pkg::IMM_I;
    dec.xfer     = id_pkg::XFER_NONE;
    illegal      = 1'b0;

    case (instr_i.r.opcode)
      id_pkg::OPC_OP: begin
        dec.alu_en = 1'b1;
        dec.alu_op = arith_op;
        dec.rf_we  = 1'b1;
        dec.rf_re  = 2'b11;
        // Only ADD/SUB and SRL/SRA have a second funct7 encoding
        illegal = !((funct7 == 7'h00) ||
                    ((funct7 == 7'h20) && ((funct3 == 3'b000) || (funct3 == 3'b101))));
      end
      id_pkg::OPC_OP_IMM: begin
        dec.alu_en   = 1'b1;
        dec.alu_op   = arith_op;
        dec.op_b_sel = id_pkg::OP_B_IMM;
        dec.rf_we    = 1'b1;
        dec.rf_re    = 2'b01;
        // Shift amounts leave funct7 as a real function field
        if (funct3 == 3'b001) begin
          illegal = (funct7 != 7'h00);
        end else if (funct3 == 3'b101) begin
          illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
        end
      end
      id_pkg::OPC_LUI, id_pkg::OPC_AUIPC: begin
        dec.alu_en   = 1'b1;
        dec.op_a_sel = (instr_i.r.opcode == id_pkg::OPC_LUI) ? id_pkg::OP_A_ZERO
                                                              : id_pkg::OP_A_PC;
        dec.op_b_sel = id_pkg::OP_B_IMM;
        dec.imm_sel  = id_pkg::IMM_U;
        dec.rf_we    = 1'b1;
      end
      id_pkg::OPC_JAL, id_pkg::OPC_JALR: begin
        // ALU forms the link value pc + 4
        dec.alu_en   = 1'b1;
        dec.op_a_sel = id_pkg::OP_A_PC;
        dec.op_b_sel = id_pkg::OP_B_IMM;
        dec.imm_sel  = id_pkg::IMM_PCINCR;
        dec.rf_we    = 1'b1;
        if (instr_i.r.opcode == id_pkg::OPC_JALR) begin
          dec.rf_re = 2'b01;
          dec.xfer  = id_pkg::XFER_JALR;
          illegal   = (funct3 != 3'b000);
        end else begin
          dec.xfer  = id_pkg::XFER_JAL;
        end
      end
      id_pkg::OPC_BRANCH: begin
        dec.alu_en   = 1'b1;
        dec.op_c_sel = id_pkg::OP_C_BCH;
        dec.rf_re    = 2'b11;
        dec.xfer     = id_pkg::XFER_BRANCH;
        // Branch compares reuse the ALU compare ops
        case (funct3)
          3'b000, 3'b001: dec.alu_op = id_pkg::ALU_XOR;
          3'b100, 3'b101: dec.alu_op = id_pkg::ALU_SLT;
          3'b110, 3'b111: dec.alu_op = id_pkg::ALU_SLTU;
          default:        illegal    = 1'b1;
        endcase
      end
      id_pkg::OPC_LOAD: begin
        // Address add in the ALU, size and sign straight from funct3
        dec.alu_en       = 1'b1;
        dec.op_b_sel     = id_pkg::OP_B_IMM;
        dec.lsu_en       = 1'b1;
        dec.lsu_size     = funct3[1:0];
        dec.lsu_unsigned = funct3[2];
        dec.rf_we        = 1'b1;
        dec.rf_re        = 2'b01;
        illegal = (funct3 == 3'b011) || (funct3 == 3'b110) || (funct3 == 3'b111);
      end
      id_pkg::OPC_STORE: begin
        dec.alu_en   = 1'b1;
        dec.op_b_sel = id_pkg::OP_B_IMM;
        dec.imm_sel  = id_pkg::IMM_S;
        dec.lsu_en   = 1'b1;
        dec.lsu_we   = 1'b1;
        dec.lsu_size = funct3[1:0];
        dec.rf_re    = 2'b11;
        illegal      = funct3[2] || (funct3[1:0] == 2'b11);
      end
      default: illegal = 1'b1;
    endcase

    // Illegal instructions must not cause any side effect downstream
    if (illegal) begin
      dec.alu_en = 1'b0;
      dec.lsu_en = 1'b0;
      dec.lsu_we = 1'b0;
      dec.rf_we  = 1'b0;
      dec.rf_re  = 2'b00;
      dec.xfer   = id_pkg::XFER_NONE;
    end
    dec.illegal = illegal;

    // Controller suppresses the write, e.g. for a squashed instruction
    if (deassert_we_i) begin
      dec.rf_we = 1'b0;
    end
  end

  assign dec_o = dec;

endmodule

`default_nettype wire

// File: id_jump_target.sv
// Branch and jump target adders of the decode stage, pure combinational
`default_nettype none

module id_jump_target (
  input  id_pkg::word_t  pc_i,
  input  id_pkg::instr_u instr_i,
  input  id_pkg::xfer_e  xfer_i,
  input  id_pkg::word_t  rs1_fw_i,
  output id_pkg::word_t  bch_target_o,
  output id_pkg::word_t  jmp_target_o
);

  id_pkg::word_t imm_b;
  id_pkg::word_t imm_j;
  id_pkg::word_t imm_i;
  id_pkg::word_t jalr_sum;

  // Reassemble the scrambled B and J offsets, sign taken from bit 31
  assign imm_b = {{19{instr_i.b.imm12}}, instr_i.b.imm12, instr_i.b.imm11,
                  instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};
  assign imm_j = {{11{instr_i.j.imm20}}, instr_i.j.imm20, instr_i.j.imm19_12,
                  instr_i.j.imm11, instr_i.j.imm10_1, 1'b0};
  assign imm_i = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};

  assign bch_target_o = pc_i + imm_b;

  // JALR clears bit 0 of the sum
  assign jalr_sum     = rs1_fw_i + imm_i;
  assign jmp_target_o = (xfer_i == id_pkg::XFER_JALR) ? {jalr_sum[31:1], 1'b0}
                                                      : pc_i + imm_j;

endmodule

`default_nettype wire

// File: id_operand_select.sv
// Operand forwarding, immediate extraction and operand A/B/C muxing for the ID stage
`default_nettype none

module id_operand_select (
  input  id_pkg::word_t   pc_i,
  input  id_pkg::instr_u  instr_i,
  input  id_pkg::decode_t dec_i,
  input  id_pkg::fw_sel_e fw_a_i,
  input  id_pkg::fw_sel_e fw_b_i,
  input  id_pkg::word_t   rf_rdata_a_i,
  input  id_pkg::word_t   rf_rdata_b_i,
  input  id_pkg::word_t   fw_ex_i,
  input  id_pkg::word_t   fw_wb_i,
  input  id_pkg::word_t   bch_target_i,
  output id_pkg::word_t   rs1_fw_o,
  output id_pkg::word_t   operand_a_o,
  output id_pkg::word_t   operand_b_o,
  output id_pkg::word_t   operand_c_o
);

  id_pkg::word_t rs2_fw;
  id_pkg::word_t imm_i;
  id_pkg::word_t imm_s;
  id_pkg::word_t imm_u;
  id_pkg::word_t imm_b;

  // Same bypass mux for both source registers
  function automatic id_pkg::word_t fw_mux(input id_pkg::fw_sel_e sel,
                                           input id_pkg::word_t   rf_data,
                                           input id_pkg::word_t   ex_data,
                                           input id_pkg::word_t   wb_data);
    case (sel)
      id_pkg::FW_EX: return ex_data;
      id_pkg::FW_WB: return wb_data;
      default:       return rf_data;
    endcase
  endfunction

  assign rs1_fw_o = fw_mux(fw_a_i, rf_rdata_a_i, fw_ex_i, fw_wb_i);
  assign rs2_fw   = fw_mux(fw_b_i, rf_rdata_b_i, fw_ex_i, fw_wb_i);

  ////////////////////
  // Immediates
  ////////////////////

  assign imm_i = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
  assign imm_s = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
  assign imm_u = {instr_i.u.imm31_12, 12'h000};

  always_comb begin
    case (dec_i.imm_sel)
      id_pkg::IMM_S:      imm_b = imm_s;
      id_pkg::IMM_U:      imm_b = imm_u;
      // Link value for JAL/JALR
      id_pkg::IMM_PCINCR: imm_b = id_pkg::PC_INCR;
      default:            imm_b = imm_i;
    endcase
  end

  ////////////////////
  // Operand muxes
  ////////////////////

  always_comb begin
    case (dec_i.op_a_sel)
      id_pkg::OP_A_PC:   operand_a_o = pc_i;
      id_pkg::OP_A_ZERO: operand_a_o = '0;
      default:           operand_a_o = rs1_fw_o;
    endcase
  end

  assign operand_b_o = (dec_i.op_b_sel == id_pkg::OP_B_IMM) ? imm_b : rs2_fw;

  // Store data, or the branch target carried to EX
  assign operand_c_o = (dec_i.op_c_sel == id_pkg::OP_C_BCH) ? bch_target_i : rs2_fw;

endmodule

`default_nettype wire

// File: id_ex_pipe_reg.sv
// ID/EX pipeline register with valid tracking, hold under EX back-pressure and bubbles
`default_nettype none

module id_ex_pipe_reg (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           load_i,
  input  logic           ex_ready_i,
  input  id_pkg::id_ex_t next_i,
  output id_pkg::id_ex_t id_ex_o
);

  id_pkg::id_ex_t id_ex_q;

  // Three cases per edge
  //   load           capture a new instruction
  //   ready, no load insert a bubble
  //   not ready      hold everything for EX
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex_q <= '0;
    end else if (load_i) begin
      id_ex_q       <= next_i;
      id_ex_q.valid <= 1'b1;
    end else if (ex_ready_i) begin
      // Payload left as is, only valid drops
      id_ex_q.valid <= 1'b0;
    end
  end

  assign id_ex_o = id_ex_q;

endmodule

`default_nettype wire

// File: id_stage.sv
// Top of the RV32I decode stage, instantiate with an external register file and EX stage
`default_nettype none

module id_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  id_pkg::if_id_t    if_id_i,
  input  id_pkg::byp_ctrl_t byp_i,
  input  id_pkg::word_t     rf_rdata_a_i,
  input  id_pkg::word_t     rf_rdata_b_i,
  input  id_pkg::word_t     fw_ex_i,
  input  id_pkg::word_t     fw_wb_i,
  input  logic              ex_ready_i,
  output id_pkg::rf_addr_t  rf_raddr_a_o,
  output id_pkg::rf_addr_t  rf_raddr_b_o,
  output id_pkg::word_t     jmp_target_o,
  output logic              id_ready_o,
  output id_pkg::id_ex_t    id_ex_o
);

  id_pkg::decode_t dec;
  id_pkg::word_t   bch_target;
  id_pkg::word_t   rs1_fw;
  id_pkg::word_t   operand_a;
  id_pkg::word_t   operand_b;
  id_pkg::word_t   operand_c;
  id_pkg::id_ex_t  next;
  logic            id_valid;
  logic            load;

  // Unused read ports are parked on x0 so no false hazard is seen
  assign rf_raddr_a_o = dec.rf_re[0] ? if_id_i.instr.r.rs1 : '0;
  assign rf_raddr_b_o = dec.rf_re[1] ? if_id_i.instr.r.rs2 : '0;

  id_decoder u_decoder (
    .instr_i       (if_id_i.instr),
    .deassert_we_i (byp_i.deassert_we),
    .dec_o         (dec)
  );

  id_jump_target u_jump_target (
    .pc_i         (if_id_i.pc),
    .instr_i      (if_id_i.instr),
    .xfer_i       (dec.xfer),
    .rs1_fw_i     (rs1_fw),
    .bch_target_o (bch_target),
    .jmp_target_o (jmp_target_o)
  );

  id_operand_select u_operand_select (
    .pc_i         (if_id_i.pc),
    .instr_i      (if_id_i.instr),
    .dec_i        (dec),
    .fw_a_i       (byp_i.fw_a),
    .fw_b_i       (byp_i.fw_b),
    .rf_rdata_a_i (rf_rdata_a_i),
    .rf_rdata_b_i (rf_rdata_b_i),
    .fw_ex_i      (fw_ex_i),
    .fw_wb_i      (fw_wb_i),
    .bch_target_i (bch_target),
    .rs1_fw_o     (rs1_fw),
    .operand_a_o  (operand_a),
    .operand_b_o  (operand_b),
    .operand_c_o  (operand_c)
  );

  ////////////////////
  // Handshake
  ////////////////////

  // Kill and halt both block the instruction, kill also frees IF
  assign id_valid   = if_id_i.valid && !byp_i.kill_id && !byp_i.halt_id;
  assign id_ready_o = byp_i.kill_id || (ex_ready_i && !byp_i.halt_id);
  assign load       = id_valid && ex_ready_i;

  // Next ID/EX contents
  always_comb begin
    next.valid        = id_valid;
    next.pc           = if_id_i.pc;
    next.alu_en       = dec.alu_en;
    next.alu_op       = dec.alu_op;
    next.operand_a    = operand_a;
    next.operand_b    = operand_b;
    next.operand_c    = operand_c;
    next.lsu_en       = dec.lsu_en;
    next.lsu_we       = dec.lsu_we;
    next.lsu_size     = dec.lsu_size;
    next.lsu_unsigned = dec.lsu_unsigned;
    next.rf_we        = dec.rf_we;
    next.rf_waddr     = if_id_i.instr.r.rd;
    next.branch       = (dec.xfer == id_pkg::XFER_BRANCH);
    next.illegal      = dec.illegal;
  end

  id_ex_pipe_reg u_id_ex_pipe_reg (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_i     (load),
    .ex_ready_i (ex_ready_i),
    .next_i     (next),
    .id_ex_o    (id_ex_o)
  );

endmodule

`default_nettype wire

// File: id_stage_asserts.sv
// Concurrent checks on the ID/EX register and handshake, bound into every id_stage
`default_nettype none

module id_stage_asserts (
  input logic              clk,
  input logic              rst_n,
  input logic              ex_ready_i,
  input id_pkg::byp_ctrl_t byp_i,
  input logic              id_ready_o,
  input id_pkg::id_ex_t    id_ex_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Register is cleared while reset is held
  valid_low_in_reset: assert property (@(posedge clk) !rst_n |-> !id_ex_o.valid)
    else $error("ID/EX valid high during reset");

  // EX stall freezes every field
  hold_under_stall: assert property (
    @(posedge clk) disable iff (!rst_n) !ex_ready_i |=> $stable(id_ex_o))
    else $error("ID/EX register changed while EX was not ready");

  // Halt without kill blocks fetch
  halt_blocks_ready: assert property (
    @(posedge clk) disable iff (!rst_n) (byp_i.halt_id && !byp_i.kill_id) |-> !id_ready_o)
    else $error("ID ready high under halt");

endmodule

bind id_stage id_stage_asserts u_id_stage_asserts (
  .clk        (clk),
  .rst_n      (rst_n),
  .ex_ready_i (ex_ready_i),
  .byp_i      (byp_i),
  .id_ready_o (id_ready_o),
  .id_ex_o    (id_ex_o)
);

`default_nettype wire

// File: tb_id_stage.sv
// Directed testbench for the RV32I decode stage, run with tb_id_stage as top module
`default_nettype none

module tb_id_stage;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 5;
  // Longest test stays well below TEST_CYCLES
  localparam int NUM_TESTS    = 6;
  localparam int TEST_CYCLES  = 30;
  localparam int WAIT_LIMIT   = 8;
  localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_TESTS * TEST_CYCLES + 20) * CLK_PERIOD;

  logic              clk = 1'b0;
  logic              rst_n;
  id_pkg::if_id_t    if_id;
  id_pkg::byp_ctrl_t byp;
  id_pkg::word_t     rf_rdata_a;
  id_pkg::word_t     rf_rdata_b;
  id_pkg::word_t     fw_ex;
  id_pkg::word_t     fw_wb;
  logic              ex_ready;
  id_pkg::rf_addr_t  rf_raddr_a;
  id_pkg::rf_addr_t  rf_raddr_b;
  id_pkg::word_t     jmp_target;
  logic              id_ready;
  id_pkg::id_ex_t    id_ex;

  // Data driven with the next instruction
  id_pkg::word_t a_val;
  id_pkg::word_t b_val;
  id_pkg::word_t ex_val;
  id_pkg::word_t wb_val;

  integer seed   = 32'hefe3;
  int     errors = 0;
  int     checks = 0;

  id_stage dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .if_id_i      (if_id),
    .byp_i        (byp),
    .rf_rdata_a_i (rf_rdata_a),
    .rf_rdata_b_i (rf_rdata_b),
    .fw_ex_i      (fw_ex),
    .fw_wb_i      (fw_wb),
    .ex_ready_i   (ex_ready),
    .rf_raddr_a_o (rf_raddr_a),
    .rf_raddr_b_o (rf_raddr_b),
    .jmp_target_o (jmp_target),
    .id_ready_o   (id_ready),
    .id_ex_o      (id_ex)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////
  // Encoders
  ////////////////////

  function automatic id_pkg::word_t enc_r(input logic [6:0] f7, input id_pkg::rf_addr_t rs2,
                                          input id_pkg::rf_addr_t rs1, input logic [2:0] f3,
                                          input id_pkg::rf_addr_t rd);
    return {f7, rs2, rs1, f3, rd, id_pkg::OPC_OP};
  endfunction

  function automatic id_pkg::word_t enc_i(input logic [11:0] imm, input id_pkg::rf_addr_t rs1,
                                          input logic [2:0] f3, input id_pkg::rf_addr_t rd,
                                          input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic id_pkg::word_t enc_s(input logic [11:0] imm, input id_pkg::rf_addr_t rs2,
                                          input id_pkg::rf_addr_t rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], id_pkg::OPC_STORE};
  endfunction

  // Offset bit 0 is implied, B and J scatter the rest
  function automatic id_pkg::word_t enc_b(input logic [12:0] imm, input id_pkg::rf_addr_t rs2,
                                          input id_pkg::rf_addr_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], id_pkg::OPC_BRANCH};
  endfunction

  function automatic id_pkg::word_t enc_u(input logic [19:0] imm, input id_pkg::rf_addr_t rd,
                                          input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic id_pkg::word_t enc_j(input logic [20:0] imm, input id_pkg::rf_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, id_pkg::OPC_JAL};
  endfunction

  function automatic id_pkg::word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic id_pkg::word_t sext13(input logic [12:0] v);
    return {{19{v[12]}}, v};
  endfunction

  function automatic id_pkg::word_t sext21(input logic [20:0] v);
    return {{11{v[20]}}, v};
  endfunction

  function automatic id_pkg::word_t rand_word();
    return $random(seed);
  endfunction

  // Writing ALU op with nothing else enabled
  function automatic id_pkg::id_ex_t base_exp(input id_pkg::word_t pc,
                                              input id_pkg::rf_addr_t rd);
    id_pkg::id_ex_t e;
    e          = '0;
    e.valid    = 1'b1;
    e.pc       = pc;
    e.alu_en   = 1'b1;
    e.alu_op   = id_pkg::ALU_ADD;
    e.rf_we    = 1'b1;
    e.rf_waddr = rd;
    return e;
  endfunction

  // Operand C and the load size fields are don't care for ALU ops
  function automatic id_pkg::id_ex_t care_default();
    id_pkg::id_ex_t m;
    m              = '1;
    m.operand_c    = '0;
    m.lsu_size     = '0;
    m.lsu_unsigned = 1'b0;
    return m;
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_word(input string what, input id_pkg::word_t got,
                            input id_pkg::word_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, want);
    end
  endtask

  task automatic check_addr(input string what, input id_pkg::rf_addr_t got,
                            input id_pkg::rf_addr_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, want);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, want);
    end
  endtask

  task automatic check_id_ex(input string what, input id_pkg::id_ex_t got,
                             input id_pkg::id_ex_t want, input id_pkg::id_ex_t care);
    logic [$bits(id_pkg::id_ex_t)-1:0] diff;
    diff = (got ^ want) & care;
    checks++;
    if (diff !== '0) begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, want);
    end
  endtask

  ////////////////////
  // Stimulus helpers
  ////////////////////

  task automatic new_data();
    a_val  = rand_word();
    b_val  = rand_word();
    ex_val = rand_word();
    wb_val = rand_word();
  endtask

  task automatic drive_instr(input id_pkg::word_t instr, input id_pkg::word_t pc,
                             input id_pkg::byp_ctrl_t ctl);
    @(posedge clk);
    if_id      <= {1'b1, pc, instr};
    byp        <= ctl;
    rf_rdata_a <= a_val;
    rf_rdata_b <= b_val;
    fw_ex      <= ex_val;
    fw_wb      <= wb_val;
  endtask

  // Drop valid after the accepting edge, then wait for the result
  task automatic wait_result();
    int n;
    n = 0;
    @(posedge clk);
    if_id.valid <= 1'b0;
    @(negedge clk);
    while (!id_ex.valid && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!id_ex.valid) begin
      errors++;
      $display("ERROR at %0t: no valid ID/EX output within %0d cycles", $time, WAIT_LIMIT);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    $display("%-20s %s", name, (errors == err_before) ? "ok" : "FAILED");
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_reset();
    int err0;
    err0 = errors;
    @(negedge clk);
    check_bit("valid after reset", id_ex.valid, 1'b0);
    check_bit("ready after reset", id_ready, 1'b1);
    new_data();
    drive_instr(enc_i(12'd5, 5'd1, 3'b000, 5'd2, id_pkg::OPC_OP_IMM), 32'h100, '0);
    // Accepted on this edge, visible one cycle later
    @(posedge clk);
    if_id.valid <= 1'b0;
    @(negedge clk);
    check_bit("valid after accept", id_ex.valid, 1'b1);
    report_test("reset", err0);
  endtask

  task automatic test_alu();
    int             err0;
    id_pkg::id_ex_t want;
    id_pkg::word_t  pc;
    id_pkg::word_t  rnd;
    logic [11:0]    imm;
    err0 = errors;
    new_data();
    rnd = rand_word();
    imm = rnd[11:0];
    pc  = rand_word() & 32'hffff_fffc;
    // ADDI x3, x4, imm
    drive_instr(enc_i(imm, 5'd4, 3'b000, 5'd3, id_pkg::OPC_OP_IMM), pc, '0);
    @(negedge clk);
    check_addr("ADDI rs1 address", rf_raddr_a, 5'd4);
    wait_result();
    want           = base_exp(pc, 5'd3);
    want.operand_a = a_val;
    want.operand_b = sext12(imm);
    check_id_ex("ADDI", id_ex, want, care_default());
    // SUB x5, x6, x7
    new_data();
    drive_instr(enc_r(7'h20, 5'd7, 5'd6, 3'b000, 5'd5), pc + 32'd4, '0);
    @(negedge clk);
    check_addr("SUB rs1 address", rf_raddr_a, 5'd6);
    check_addr("SUB rs2 address", rf_raddr_b, 5'd7);
    wait_result();
    want           = base_exp(pc + 32'd4, 5'd5);
    want.alu_op    = id_pkg::ALU_SUB;
    want.operand_a = a_val;
    want.operand_b = b_val;
    check_id_ex("SUB", id_ex, want, care_default());
    report_test("alu", err0);
  endtask

  task automatic test_fwd_utype();
    int                err0;
    id_pkg::id_ex_t    want;
    id_pkg::byp_ctrl_t ctl;
    id_pkg::word_t     pc;
    id_pkg::word_t     rnd;
    err0 = errors;
    new_data();
    pc       = rand_word() & 32'hffff_fffc;
    ctl      = '0;
    ctl.fw_a = id_pkg::FW_EX;
    ctl.fw_b = id_pkg::FW_WB;
    drive_instr(enc_r(7'h20, 5'd9, 5'd8, 3'b000, 5'd12), pc, ctl);
    wait_result();
    want           = base_exp(pc, 5'd12);
    want.alu_op    = id_pkg::ALU_SUB;
    want.operand_a = ex_val;
    want.operand_b = wb_val;
    check_id_ex("SUB forwarded", id_ex, want, care_default());
    // LUI adds the U immediate to zero
    rnd = rand_word();
    drive_instr(enc_u(rnd[31:12], 5'd13, id_pkg::OPC_LUI), pc, '0);
    wait_result();
    want           = base_exp(pc, 5'd13);
    want.operand_a = '0;
    want.operand_b = {rnd[31:12], 12'h000};
    check_id_ex("LUI", id_ex, want, care_default());
    drive_instr(enc_u(rnd[31:12], 5'd14, id_pkg::OPC_AUIPC), pc, '0);
    wait_result();
    want           = base_exp(pc, 5'd14);
    want.operand_a = pc;
    want.operand_b = {rnd[31:12], 12'h000};
    check_id_ex("AUIPC", id_ex, want, care_default());
    report_test("fwd_utype", err0);
  endtask

  task automatic test_xfer();
    int             err0;
    id_pkg::id_ex_t want;
    id_pkg::word_t  pc;
    id_pkg::word_t  rnd;
    logic [20:0]    imm_j;
    logic [12:0]    imm_b;
    logic [11:0]    imm;
    err0  = errors;
    new_data();
    pc    = rand_word() & 32'hffff_fffc;
    rnd   = rand_word();
    imm_j = {rnd[20:1], 1'b0};
    drive_instr(enc_j(imm_j, 5'd1), pc, '0);
    @(negedge clk);
    check_word("JAL target", jmp_target, pc + sext21(imm_j));
    wait_result();
    // Link value pc + 4 is formed in EX
    want           = base_exp(pc, 5'd1);
    want.operand_a = pc;
    want.operand_b = 32'd4;
    check_id_ex("JAL", id_ex, want, care_default());
    imm = rnd[31:20];
    drive_instr(enc_i(imm, 5'd2, 3'b000, 5'd1, id_pkg::OPC_JALR), pc, '0);
    @(negedge clk);
    check_word("JALR target", jmp_target, (a_val + sext12(imm)) & 32'hffff_fffe);
    wait_result();
    check_word("JALR operand_b", id_ex.operand_b, 32'd4);
    imm_b = {rnd[12:1], 1'b0};
    drive_instr(enc_b(imm_b, 5'd3, 5'd2, 3'b000), pc, '0);
    wait_result();
    check_word("BEQ operand_c", id_ex.operand_c, pc + sext13(imm_b));
    check_bit("BEQ branch", id_ex.branch, 1'b1);
    check_bit("BEQ rf_we", id_ex.rf_we, 1'b0);
    // SW x5, imm(x6)
    drive_instr(enc_s(imm, 5'd5, 5'd6, 3'b010), pc, '0);
    wait_result();
    check_word("SW operand_a", id_ex.operand_a, a_val);
    check_word("SW operand_b", id_ex.operand_b, sext12(imm));
    check_word("SW operand_c", id_ex.operand_c, b_val);
    check_bit("SW lsu_en", id_ex.lsu_en, 1'b1);
    check_bit("SW lsu_we", id_ex.lsu_we, 1'b1);
    check_bit("SW rf_we", id_ex.rf_we, 1'b0);
    report_test("xfer", err0);
  endtask

  task automatic test_stall_kill();
    int                err0;
    id_pkg::id_ex_t    want;
    id_pkg::byp_ctrl_t ctl;
    id_pkg::word_t     pc;
    id_pkg::word_t     rnd;
    logic [11:0]       imm;
    err0 = errors;
    new_data();
    pc  = rand_word() & 32'hffff_fffc;
    rnd = rand_word();
    imm = rnd[11:0];
    drive_instr(enc_i(imm, 5'd4, 3'b000, 5'd8, id_pkg::OPC_OP_IMM), pc, '0);
    want           = base_exp(pc, 5'd8);
    want.operand_a = a_val;
    want.operand_b = sext12(imm);
    // First instruction is taken here, EX stalls from the next edge
    @(posedge clk);
    ex_ready <= 1'b0;
    if_id    <= {1'b1, pc + 32'd4, enc_i(imm, 5'd4, 3'b000, 5'd9, id_pkg::OPC_OP_IMM)};
    repeat (3) begin
      @(negedge clk);
      check_id_ex("held under stall", id_ex, want, care_default());
      check_bit("ready under stall", id_ready, 1'b0);
    end
    @(posedge clk);
    ex_ready <= 1'b1;
    wait_result();
    want.pc       = pc + 32'd4;
    want.rf_waddr = 5'd9;
    check_id_ex("after stall", id_ex, want, care_default());
    // Killed instruction never reaches EX
    ctl         = '0;
    ctl.kill_id = 1'b1;
    drive_instr(enc_i(imm, 5'd4, 3'b000, 5'd10, id_pkg::OPC_OP_IMM), pc, ctl);
    repeat (2) begin
      @(negedge clk);
      check_bit("ready under kill", id_ready, 1'b1);
      check_bit("valid under kill", id_ex.valid, 1'b0);
    end
    @(posedge clk);
    if_id.valid <= 1'b0;
    byp         <= '0;
    // Halted instruction stays in ID and fetch is blocked
    ctl         = '0;
    ctl.halt_id = 1'b1;
    drive_instr(enc_i(imm, 5'd4, 3'b000, 5'd11, id_pkg::OPC_OP_IMM), pc, ctl);
    repeat (2) begin
      @(negedge clk);
      check_bit("ready under halt", id_ready, 1'b0);
      check_bit("valid under halt", id_ex.valid, 1'b0);
    end
    @(posedge clk);
    if_id.valid <= 1'b0;
    byp         <= '0;
    report_test("stall_kill", err0);
  endtask

  task automatic test_illegal();
    int                err0;
    id_pkg::byp_ctrl_t ctl;
    err0 = errors;
    new_data();
    drive_instr(enc_i(12'h000, 5'd0, 3'b000, 5'd10, 7'h7f), 32'h200, '0);
    wait_result();
    check_bit("illegal flag", id_ex.illegal, 1'b1);
    check_bit("illegal rf_we", id_ex.rf_we, 1'b0);
    check_bit("illegal alu_en", id_ex.alu_en, 1'b0);
    check_bit("illegal lsu_en", id_ex.lsu_en, 1'b0);
    ctl             = '0;
    ctl.deassert_we = 1'b1;
    drive_instr(enc_r(7'h00, 5'd7, 5'd6, 3'b000, 5'd11), 32'h204, ctl);
    wait_result();
    check_bit("deassert rf_we", id_ex.rf_we, 1'b0);
    check_bit("deassert alu_en", id_ex.alu_en, 1'b1);
    check_bit("deassert illegal", id_ex.illegal, 1'b0);
    check_word("deassert operand_a", id_ex.operand_a, a_val);
    report_test("illegal", err0);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    rst_n      = 1'b0;
    if_id      = '0;
    byp        = '0;
    rf_rdata_a = '0;
    rf_rdata_b = '0;
    fw_ex      = '0;
    fw_wb      = '0;
    ex_ready   = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    test_reset();
    test_alu();
    test_fwd_utype();
    test_xfer();
    test_stall_kill();
    test_illegal();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Bound derived from test count and the longest test
  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
id_pkg.sv
id_decoder.sv
id_jump_target.sv
id_operand_select.sv
id_ex_pipe_reg.sv
id_stage.sv
id_stage_asserts.sv
tb_id_stage.sv

// File: Makefile
SIM        := verilator
TOP        := tb_id_stage
FILELIST   := project.f
FLAGS      := --timing --assert --timescale 1ns/1ps
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
